/* rvcpu.f */
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_regfile.sv
hw/rv_exec.sv
hw/rv_lsu.sv
hw/rv_bus_arbiter.sv
hw/rvcpu.sv
verif/tb_rvcpu.sv

/* Makefile */
# Verilator build and run for the rvcpu testbench

VERILATOR ?= verilator
TOP       ?= tb_rvcpu
FILELIST  ?= rvcpu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/tb_rvcpu.sv */
// testbench for rvcpu with bus memory model, random program generator, reference model, checks
`timescale 1ns/10ps

module tb_rvcpu import rv_pkg::*; ();

   localparam addr_t RESET_PC        = 32'h0000_0000;
   localparam int    CLK_PERIOD      = 8;
   localparam int    NUM_INST        = 40;
   localparam int    MEM_WORDS       = 512;
   localparam addr_t DATA_BASE       = 32'h0000_0400;
   localparam addr_t LOOP_PC         = RESET_PC + 32'(4 * (NUM_INST - 1));
   // two runs, about 12 cycles per instruction plus margin
   localparam int    WATCHDOG_CYCLES = 2 * (NUM_INST * 12 + 100) + 10;

   localparam int K_LUI  = 0;
   localparam int K_ADDI = 1;
   localparam int K_ADD  = 2;
   localparam int K_SUB  = 3;
   localparam int K_AND  = 4;
   localparam int K_OR   = 5;
   localparam int K_XOR  = 6;
   localparam int K_SLT  = 7;
   localparam int K_LW   = 8;
   localparam int K_SW   = 9;
   localparam int K_BEQ  = 10;
   localparam int K_BNE  = 11;
   localparam int K_JAL  = 12;

   localparam int CAT_FETCH = 0;
   localparam int CAT_DATA  = 1;
   localparam int CAT_MEM   = 2;
   localparam int CAT_OTHER = 3;

   logic     clk          = 1'b0;
   logic     arst_n_i     = 1'b0;
   logic     mem_ena_o;
   bus_req_t mem_req_o;
   word_t    mem_rdata_i  = '0;
   logic     mem_finish_i = 1'b0;

   integer      seed = 87675;
   int          err_cnt [4] = '{0, 0, 0, 0};
   word_t       mem [MEM_WORDS];
   word_t       ref_mem [MEM_WORDS];
   word_t       ref_x [32];
   addr_t       ref_pc;
   int          p_kind [NUM_INST];
   int          p_rd [NUM_INST];
   int          p_rs1 [NUM_INST];
   int          p_rs2 [NUM_INST];
   word_t       p_imm [NUM_INST];
   word_t       p_word [NUM_INST];
   logic        exp_data;
   logic        exp_we;
   addr_t       exp_addr;
   word_t       exp_wdata;
   int          fetch_cnt;
   int          loop_hits;
   logic        loop_done  = 1'b0;
   logic        run_active = 1'b0;
   logic        busy       = 1'b0;
   int          wait_cnt   = 0;
   int          max_delay  = 0;
   word_t       resp_word;
   logic [63:0] stores_cur [$];
   logic [63:0] stores_first [$];

   always #(CLK_PERIOD / 2) clk = ~clk;

   rvcpu #(
      .RESET_PC (RESET_PC)
   ) u_dut (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .mem_ena_o    (mem_ena_o),
      .mem_req_o    (mem_req_o),
      .mem_rdata_i  (mem_rdata_i),
      .mem_finish_i (mem_finish_i)
   );

   task automatic check_value(input int cat, input string name, input word_t got,
                              input word_t exp);
      assert (got === exp) else begin
         err_cnt[cat]++;
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic int word_index(input addr_t a);
      return int'(a[10:2]);
   endfunction

   function automatic word_t sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                   input logic [2:0] f3, input int rd);
      return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
   endfunction

   function automatic word_t enc_i(input word_t imm, input int rs1, input logic [2:0] f3,
                                   input int rd, input logic [6:0] opc);
      return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
   endfunction

   function automatic word_t enc_s(input word_t imm, input int rs2, input int rs1);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic word_t enc_b(input word_t imm, input int rs2, input int rs1,
                                   input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic word_t enc_u(input word_t imm, input int rd);
      return {imm[31:12], rd[4:0], 7'b0110111};
   endfunction

   function automatic word_t enc_j(input word_t imm, input int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
   endfunction

   task automatic place(input int n, input int kind, input int rd, input int rs1,
                        input int rs2, input word_t imm, input word_t word);
      p_kind[n] = kind;
      p_rd[n]   = rd;
      p_rs1[n]  = rs1;
      p_rs2[n]  = rs2;
      p_imm[n]  = imm;
      p_word[n] = word;
   endtask

   task automatic build_program();
      int    kind;
      int    rd;
      int    rs1;
      int    rs2;
      int    off;
      word_t r;
      word_t imm;
      word_t word;
      // x8 is the data base and is never a destination
      place(0, K_ADDI, 8, 0, 0, DATA_BASE, enc_i(DATA_BASE, 0, 3'b000, 8, 7'b0010011));
      for (int i = 1; i < 8; i++) begin
         r   = $random(seed);
         imm = {r[31:12], 12'b0};
         place(2 * i - 1, K_LUI, i, 0, 0, imm, enc_u(imm, i));
         imm = sext12(r[11:0]);
         place(2 * i, K_ADDI, i, i, 0, imm, enc_i(imm, i, 3'b000, i, 7'b0010011));
      end
      for (int n = 15; n < NUM_INST - 1; n++) begin
         kind = rand_below(13);
         rd   = rand_below(8);
         rs1  = rand_below(9);
         rs2  = rand_below(9);
         r    = $random(seed);
         // forward targets only, at most four instructions ahead
         off  = 1 + rand_below((NUM_INST - 1 - n < 4) ? NUM_INST - 1 - n : 4);
         imm  = '0;
         case (kind)
            K_LUI: begin
               imm  = {r[31:12], 12'b0};
               word = enc_u(imm, rd);
            end
            K_ADDI: begin
               imm  = sext12(r[11:0]);
               word = enc_i(imm, rs1, 3'b000, rd, 7'b0010011);
            end
            K_ADD:   word = enc_r(7'h00, rs2, rs1, 3'b000, rd);
            K_SUB:   word = enc_r(7'h20, rs2, rs1, 3'b000, rd);
            K_AND:   word = enc_r(7'h00, rs2, rs1, 3'b111, rd);
            K_OR:    word = enc_r(7'h00, rs2, rs1, 3'b110, rd);
            K_XOR:   word = enc_r(7'h00, rs2, rs1, 3'b100, rd);
            K_SLT:   word = enc_r(7'h00, rs2, rs1, 3'b010, rd);
            K_LW: begin
               rs1  = 8;
               imm  = 32'(4 * rand_below(16));
               word = enc_i(imm, 8, 3'b010, rd, 7'b0000011);
            end
            K_SW: begin
               rs1  = 8;
               imm  = 32'(4 * rand_below(16));
               word = enc_s(imm, rs2, 8);
            end
            K_BEQ, K_BNE: begin
               // equal operands half the time so beq gets taken too
               rs2  = r[0] ? rs1 : rs2;
               imm  = 32'(4 * off);
               word = enc_b(imm, rs2, rs1, (kind == K_BNE) ? 3'b001 : 3'b000);
            end
            default: begin
               imm  = 32'(4 * off);
               word = enc_j(imm, rd);
            end
         endcase
         place(n, kind, rd, rs1, rs2, imm, word);
      end
      place(NUM_INST - 1, K_JAL, 0, 0, 0, '0, enc_j('0, 0));
   endtask

   task automatic load_memories();
      addr_t a;
      for (int i = 0; i < MEM_WORDS; i++) begin
         a          = 32'(4 * i);
         mem[i]     = (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
         ref_mem[i] = mem[i];
      end
      for (int i = 0; i < NUM_INST; i++) begin
         mem[word_index(RESET_PC + 32'(4 * i))]     = p_word[i];
         ref_mem[word_index(RESET_PC + 32'(4 * i))] = p_word[i];
      end
   endtask

   task automatic write_reg(input int rd, input word_t v);
      if (rd != 0) begin
         ref_x[rd] = v;
      end
   endtask

   // executes one instruction of the program on the reference state
   task automatic step_model(input int i);
      word_t a;
      word_t b;
      addr_t next_pc;
      a       = ref_x[p_rs1[i]];
      b       = ref_x[p_rs2[i]];
      next_pc = ref_pc + 32'd4;
      case (p_kind[i])
         K_LUI:  write_reg(p_rd[i], p_imm[i]);
         K_ADDI: write_reg(p_rd[i], a + p_imm[i]);
         K_ADD:  write_reg(p_rd[i], a + b);
         K_SUB:  write_reg(p_rd[i], a - b);
         K_AND:  write_reg(p_rd[i], a & b);
         K_OR:   write_reg(p_rd[i], a | b);
         K_XOR:  write_reg(p_rd[i], a ^ b);
         K_SLT:  write_reg(p_rd[i], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
         K_LW: begin
            exp_data = 1'b1;
            exp_we   = 1'b0;
            exp_addr = a + p_imm[i];
            write_reg(p_rd[i], ref_mem[word_index(exp_addr)]);
         end
         K_SW: begin
            exp_data  = 1'b1;
            exp_we    = 1'b1;
            exp_addr  = a + p_imm[i];
            exp_wdata = b;
            ref_mem[word_index(exp_addr)] = b;
         end
         K_BEQ:  next_pc = (a == b) ? ref_pc + p_imm[i] : next_pc;
         K_BNE:  next_pc = (a != b) ? ref_pc + p_imm[i] : next_pc;
         default: begin
            write_reg(p_rd[i], ref_pc + 32'd4);
            next_pc = ref_pc + p_imm[i];
         end
      endcase
      ref_pc = next_pc;
   endtask

   task automatic serve_access();
      bus_req_t req;
      int       idx;
      req = mem_req_o;
      idx = word_index(req.addr);
      if (!exp_data) begin
         if (fetch_cnt == 0) begin
            check_value(CAT_OTHER, "first fetch mem_req_o.addr", req.addr, RESET_PC);
         end
         fetch_cnt++;
         check_value(CAT_FETCH, "fetch mem_req_o.we", {31'b0, req.we}, 32'd0);
         check_value(CAT_FETCH, "fetch mem_req_o.addr", req.addr, ref_pc);
         if (ref_pc == LOOP_PC) begin
            loop_hits++;
         end
         step_model(int'((ref_pc - RESET_PC) >> 2));
      end else begin
         check_value(CAT_DATA, "data mem_req_o.we", {31'b0, req.we}, {31'b0, exp_we});
         check_value(CAT_DATA, "data mem_req_o.addr", req.addr, exp_addr);
         if (exp_we) begin
            check_value(CAT_DATA, "store mem_req_o.wdata", req.wdata, exp_wdata);
         end
         if (req.we) begin
            stores_cur.push_back({req.addr, req.wdata});
         end
         exp_data = 1'b0;
      end
      if (req.we) begin
         mem[idx] = req.wdata;
      end
      resp_word = mem[idx];
      // second fetch of the final jal proves the self-loop
      if (loop_hits == 2) begin
         loop_done  = 1'b1;
         run_active = 1'b0;
      end
   endtask

   // memory model, answers after 0 to max_delay extra cycles
   always @(negedge clk) begin
      if (mem_finish_i) begin
         mem_finish_i <= 1'b0;
      end else if (run_active && mem_ena_o) begin
         if (!busy) begin
            busy     = 1'b1;
            wait_cnt = (max_delay == 0) ? 0 : rand_below(max_delay + 1);
         end
         if (wait_cnt == 0) begin
            busy = 1'b0;
            serve_access();
            mem_rdata_i  <= resp_word;
            mem_finish_i <= 1'b1;
         end else begin
            wait_cnt--;
         end
      end
   end

   task automatic run_program(input int delay_max);
      arst_n_i   = 1'b0;
      load_memories();
      ref_pc     = RESET_PC;
      ref_x      = '{default: '0};
      exp_data   = 1'b0;
      fetch_cnt  = 0;
      loop_hits  = 0;
      loop_done  = 1'b0;
      busy       = 1'b0;
      wait_cnt   = 0;
      max_delay  = delay_max;
      stores_cur.delete();
      @(negedge clk);
      check_value(CAT_OTHER, "mem_ena_o in reset", {31'b0, mem_ena_o}, 32'd0);
      run_active = 1'b1;
      @(negedge clk);
      check_value(CAT_OTHER, "mem_ena_o in reset", {31'b0, mem_ena_o}, 32'd0);
      arst_n_i = 1'b1;
      @(negedge clk);
      check_value(CAT_OTHER, "mem_ena_o after reset", {31'b0, mem_ena_o}, 32'd0);
      wait (loop_done);
      for (int i = 0; i < MEM_WORDS; i++) begin
         check_value(CAT_MEM, $sformatf("mem word %h", 32'(4 * i)), mem[i], ref_mem[i]);
      end
   endtask

   initial begin
      int total;
      build_program();
      run_program(3);
      stores_first = stores_cur;
      // same program again with an immediate memory
      @(negedge clk);
      run_program(0);
      check_value(CAT_DATA, "store count", stores_cur.size(), stores_first.size());
      for (int i = 0; i < stores_cur.size() && i < stores_first.size(); i++) begin
         check_value(CAT_DATA, "store address", stores_cur[i][63:32], stores_first[i][63:32]);
         check_value(CAT_DATA, "store data", stores_cur[i][31:0], stores_first[i][31:0]);
      end
      total = err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3];
      $display("errors: fetch %0d, data access %0d, memory %0d, other %0d",
               err_cnt[CAT_FETCH], err_cnt[CAT_DATA], err_cnt[CAT_MEM], err_cnt[CAT_OTHER]);
      if (total == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, final loop never reached", WATCHDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

endmodule

/* hw/rvcpu.sv */
// core top level, fetch, exec, regfile, lsu and bus arbiter
`timescale 1ns/10ps

module rvcpu import rv_pkg::*; #(
   parameter addr_t RESET_PC = '0
) (
   input  logic     clk,
   input  logic     arst_n_i,
   output logic     mem_ena_o,
   output bus_req_t mem_req_o,
   input  word_t    mem_rdata_i,
   input  logic     mem_finish_i
);

   // fetch side
   logic      fetch_go;
   logic      redirect;
   addr_t     next_pc;
   logic      if_req;
   bus_req_t  if_bus;
   logic      if_done;
   logic      inst_valid;
   inst_t     inst;
   addr_t     pc;

   // register file
   reg_addr_t rs1;
   reg_addr_t rs2;
   word_t     rs1_data;
   word_t     rs2_data;
   logic      rd_we;
   reg_addr_t rd;
   word_t     rd_data;

   // load/store side
   logic      lsu_go;
   addr_t     lsu_addr;
   word_t     lsu_wdata;
   logic      lsu_we;
   logic      lsu_done;
   word_t     lsu_rdata;
   logic      ls_req;
   bus_req_t  ls_bus;
   logic      ls_done;

   rv_fetch #(
      .RESET_PC (RESET_PC)
   ) u_fetch (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .fetch_go_i   (fetch_go),
      .redirect_i   (redirect),
      .next_pc_i    (next_pc),
      .req_o        (if_req),
      .req_data_o   (if_bus),
      .done_i       (if_done),
      .rdata_i      (mem_rdata_i),
      .inst_valid_o (inst_valid),
      .inst_o       (inst),
      .pc_o         (pc)
   );

   rv_regfile u_regfile (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .raddr1_i (rs1),
      .raddr2_i (rs2),
      .rdata1_o (rs1_data),
      .rdata2_o (rs2_data),
      .we_i     (rd_we),
      .waddr_i  (rd),
      .wdata_i  (rd_data)
   );

   rv_exec u_exec (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .inst_valid_i (inst_valid),
      .inst_i       (inst),
      .pc_i         (pc),
      .fetch_go_o   (fetch_go),
      .redirect_o   (redirect),
      .next_pc_o    (next_pc),
      .rs1_o        (rs1),
      .rs2_o        (rs2),
      .rs1_data_i   (rs1_data),
      .rs2_data_i   (rs2_data),
      .rd_we_o      (rd_we),
      .rd_o         (rd),
      .rd_data_o    (rd_data),
      .lsu_go_o     (lsu_go),
      .lsu_addr_o   (lsu_addr),
      .lsu_wdata_o  (lsu_wdata),
      .lsu_we_o     (lsu_we),
      .lsu_done_i   (lsu_done),
      .lsu_rdata_i  (lsu_rdata)
   );

   rv_lsu u_lsu (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .go_i       (lsu_go),
      .addr_i     (lsu_addr),
      .wdata_i    (lsu_wdata),
      .we_i       (lsu_we),
      .req_o      (ls_req),
      .req_data_o (ls_bus),
      .done_i     (ls_done),
      .rdata_i    (mem_rdata_i),
      .done_o     (lsu_done),
      .rdata_o    (lsu_rdata)
   );

   rv_bus_arbiter u_arbiter (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .if_req_i     (if_req),
      .if_bus_i     (if_bus),
      .if_done_o    (if_done),
      .ls_req_i     (ls_req),
      .ls_bus_i     (ls_bus),
      .ls_done_o    (ls_done),
      .mem_ena_o    (mem_ena_o),
      .mem_req_o    (mem_req_o),
      .mem_finish_i (mem_finish_i)
   );

endmodule

/* hw/rv_bus_arbiter.sv */
// fixed-priority arbiter of fetch and data ports onto one memory bus
`timescale 1ns/10ps

module rv_bus_arbiter import rv_pkg::*; (
   input  logic     clk,
   input  logic     arst_n_i,
   input  logic     if_req_i,
   input  bus_req_t if_bus_i,
   output logic     if_done_o,
   input  logic     ls_req_i,
   input  bus_req_t ls_bus_i,
   output logic     ls_done_o,
   output logic     mem_ena_o,
   output bus_req_t mem_req_o,
   input  logic     mem_finish_i
);

   logic busy_q;
   logic own_ls_q;
   logic sel_ls;

   // locked owner wins, otherwise data port before fetch
   assign sel_ls = busy_q ? own_ls_q : ls_req_i;

   assign mem_ena_o = sel_ls ? ls_req_i : if_req_i;
   assign mem_req_o = sel_ls ? ls_bus_i : if_bus_i;
   assign if_done_o = mem_finish_i & ~sel_ls;
   assign ls_done_o = mem_finish_i & sel_ls;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q   <= 1'b0;
         own_ls_q <= 1'b0;
      end else if (mem_finish_i) begin
         busy_q <= 1'b0;
      end else if (mem_ena_o && !busy_q) begin
         busy_q   <= 1'b1;
         own_ls_q <= sel_ls;
      end
   end

   a_finish_in_access: assert property (@(posedge clk) disable iff (!arst_n_i)
      mem_finish_i |-> mem_ena_o)
      else $error("mem_finish_i without an open access");

endmodule

/* hw/rv_lsu.sv */
// load/store unit, memory step to bus request, load data capture
`timescale 1ns/10ps

module rv_lsu import rv_pkg::*; (
   input  logic     clk,
   input  logic     arst_n_i,
   input  logic     go_i,
   input  addr_t    addr_i,
   input  word_t    wdata_i,
   input  logic     we_i,
   output logic     req_o,
   output bus_req_t req_data_o,
   input  logic     done_i,
   input  word_t    rdata_i,
   output logic     done_o,
   output word_t    rdata_o
);

   logic     req_q;
   logic     done_q;
   bus_req_t req_data_q;
   word_t    rdata_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         req_q  <= 1'b0;
         done_q <= 1'b0;
      end else begin
         if (go_i) begin
            req_q <= 1'b1;
         end else if (done_i) begin
            req_q <= 1'b0;
         end
         done_q <= req_q & done_i;
      end
   end

   always_ff @(posedge clk) begin
      if (go_i) begin
         req_data_q <= '{addr: addr_i, wdata: wdata_i, we: we_i};
      end
      // stores capture too, exec ignores it
      if (req_q && done_i) begin
         rdata_q <= rdata_i;
      end
   end

   assign req_o      = req_q;
   assign req_data_o = req_data_q;
   assign done_o     = done_q;
   assign rdata_o    = rdata_q;

   a_word_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
      go_i |=> req_data_o.addr[1:0] == 2'b00)
      else $error("misaligned data access at %h", req_data_o.addr);

endmodule

/* hw/rv_exec.sv */
// sequencer FSM, decoder, ALU, branch and jump target, writeback select
`timescale 1ns/10ps

module rv_exec import rv_pkg::*; (
   input  logic      clk,
   input  logic      arst_n_i,
   input  logic      inst_valid_i,
   input  inst_t     inst_i,
   input  addr_t     pc_i,
   output logic      fetch_go_o,
   output logic      redirect_o,
   output addr_t     next_pc_o,
   output reg_addr_t rs1_o,
   output reg_addr_t rs2_o,
   input  word_t     rs1_data_i,
   input  word_t     rs2_data_i,
   output logic      rd_we_o,
   output reg_addr_t rd_o,
   output word_t     rd_data_o,
   output logic      lsu_go_o,
   output addr_t     lsu_addr_o,
   output word_t     lsu_wdata_o,
   output logic      lsu_we_o,
   input  logic      lsu_done_i,
   input  word_t     lsu_rdata_i
);

   seq_state_e state_q;
   seq_state_e state_d;
   logic [1:0] boot_q;
   op_e        op;
   alu_op_e    alu_op;
   logic [2:0] funct3;
   logic       f3_ok;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_u;
   word_t      imm_j;
   word_t      alu_b;
   word_t      alu_res;
   addr_t      link_pc;
   logic       is_mem;
   logic       taken;
   logic       retire;

   assign funct3 = inst_i[14:12];
   assign f3_ok  = funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
   assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
   assign imm_s  = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
   assign imm_b  = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
   assign imm_u  = {inst_i[31:12], 12'b0};
   assign imm_j  = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21],
                    1'b0};

   // decode, unsupported funct3/funct7 fall to ILLEGAL
   always_comb begin
      case (inst_i[6:0])
         LUI:    op = LUI;
         OP_IMM: op = f3_ok ? OP_IMM : ILLEGAL;
         OP:     op = (f3_ok && (inst_i[31:25] == 7'b0 ||
                       (inst_i[31:25] == 7'b0100000 && funct3 == 3'b000))) ? OP : ILLEGAL;
         LOAD:   op = (funct3 == 3'b010) ? LOAD : ILLEGAL;
         STORE:  op = (funct3 == 3'b010) ? STORE : ILLEGAL;
         BRANCH: op = (funct3[2:1] == 2'b00) ? BRANCH : ILLEGAL;
         JAL:    op = JAL;
         default: op = ILLEGAL;
      endcase
   end

   always_comb begin
      alu_op = ALU_ADD;
      alu_b  = imm_i;
      case (op)
         LUI: begin
            alu_op = ALU_PASS_B;
            alu_b  = imm_u;
         end
         OP_IMM, OP: begin
            alu_b = (op == OP) ? rs2_data_i : imm_i;
            case (funct3)
               3'b010:  alu_op = ALU_SLT;
               3'b100:  alu_op = ALU_XOR;
               3'b110:  alu_op = ALU_OR;
               3'b111:  alu_op = ALU_AND;
               default: alu_op = (op == OP && inst_i[30]) ? ALU_SUB : ALU_ADD;
            endcase
         end
         STORE:   alu_b = imm_s;
         default: alu_b = imm_i;
      endcase
   end

   always_comb begin
      case (alu_op)
         ALU_SUB:    alu_res = rs1_data_i - alu_b;
         ALU_AND:    alu_res = rs1_data_i & alu_b;
         ALU_OR:     alu_res = rs1_data_i | alu_b;
         ALU_XOR:    alu_res = rs1_data_i ^ alu_b;
         ALU_SLT:    alu_res = {31'b0, $signed(rs1_data_i) < $signed(alu_b)};
         ALU_PASS_B: alu_res = alu_b;
         default:    alu_res = rs1_data_i + alu_b;
      endcase
   end

   // beq on funct3[0] clear, bne on set
   assign taken   = funct3[0] ? (rs1_data_i != rs2_data_i) : (rs1_data_i == rs2_data_i);
   assign link_pc = pc_i + 32'd4;
   assign is_mem  = (op == LOAD) || (op == STORE);

   always_comb begin
      state_d = state_q;
      case (state_q)
         FETCH:   if (inst_valid_i) state_d = EXEC;
         EXEC:    state_d = is_mem ? MEM : FETCH;
         MEM:     if (lsu_done_i) state_d = WB;
         default: state_d = FETCH;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= FETCH;
         boot_q  <= 2'b00;
      end else begin
         state_q <= state_d;
         boot_q  <= {boot_q[0], 1'b1};
      end
   end

   assign retire     = (state_q == EXEC && !is_mem) || state_q == WB;
   // first fetch is kicked once, one cycle after reset release
   assign fetch_go_o = retire || (boot_q == 2'b01);
   assign redirect_o = (state_q == EXEC) && (op == JAL || (op == BRANCH && taken));
   assign next_pc_o  = pc_i + ((op == JAL) ? imm_j : imm_b);

   assign rs1_o     = inst_i[19:15];
   assign rs2_o     = inst_i[24:20];
   assign rd_o      = inst_i[11:7];
   assign rd_we_o   = (state_q == EXEC && op inside {LUI, OP_IMM, OP, JAL}) ||
                      (state_q == WB && op == LOAD);
   assign rd_data_o = (state_q == WB) ? lsu_rdata_i : ((op == JAL) ? link_pc : alu_res);

   assign lsu_go_o    = (state_q == EXEC) && is_mem;
   assign lsu_addr_o  = alu_res;
   assign lsu_wdata_o = rs2_data_i;
   assign lsu_we_o    = (op == STORE);

   a_legal_inst: assert property (@(posedge clk) disable iff (!arst_n_i)
      state_q == EXEC |-> op != ILLEGAL)
      else $error("illegal instruction %h at pc %h retired as no-op", inst_i, pc_i);

endmodule

/* hw/rv_regfile.sv */
// general register file, x0 tied to zero, two read ports, one write port
`timescale 1ns/10ps

module rv_regfile import rv_pkg::*; (
   input  logic      clk,
   input  logic      arst_n_i,
   input  reg_addr_t raddr1_i,
   input  reg_addr_t raddr2_i,
   output word_t     rdata1_o,
   output word_t     rdata2_o,
   input  logic      we_i,
   input  reg_addr_t waddr_i,
   input  word_t     wdata_i
);

   word_t regs_q [32];

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < 32; i++) begin
            regs_q[i] <= '0;
         end
      end else if (we_i && waddr_i != '0) begin
         regs_q[waddr_i] <= wdata_i;
      end
   end

   assign rdata1_o = regs_q[raddr1_i];
   assign rdata2_o = regs_q[raddr2_i];

   // x0 is only ever cleared, the write gate drops every write to it
   a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
      regs_q[0] == '0)
      else $error("x0 reads nonzero after a write to it");

endmodule

/* hw/rv_fetch.sv */
// program counter, instruction register, fetch request and redirect
`timescale 1ns/10ps

module rv_fetch import rv_pkg::*; #(
   parameter addr_t RESET_PC = '0
) (
   input  logic     clk,
   input  logic     arst_n_i,
   input  logic     fetch_go_i,
   input  logic     redirect_i,
   input  addr_t    next_pc_i,
   output logic     req_o,
   output bus_req_t req_data_o,
   input  logic     done_i,
   input  word_t    rdata_i,
   output logic     inst_valid_o,
   output inst_t    inst_o,
   output addr_t    pc_o
);

   addr_t fetch_pc_q;
   logic  req_q;
   logic  valid_q;
   inst_t inst_q;
   addr_t pc_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         req_q      <= 1'b0;
         valid_q    <= 1'b0;
         fetch_pc_q <= RESET_PC;
      end else begin
         if (fetch_go_i) begin
            req_q <= 1'b1;
         end else if (done_i) begin
            req_q <= 1'b0;
         end
         valid_q <= req_q & done_i;
         // taken branch or jal overrides the sequential pc
         if (redirect_i) begin
            fetch_pc_q <= next_pc_i;
         end else if (req_q && done_i) begin
            fetch_pc_q <= fetch_pc_q + 32'd4;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req_q && done_i) begin
         inst_q <= rdata_i;
         pc_q   <= fetch_pc_q;
      end
   end

   assign req_o        = req_q;
   assign req_data_o   = '{addr: fetch_pc_q, wdata: '0, we: 1'b0};
   assign inst_valid_o = valid_q;
   assign inst_o       = inst_q;
   assign pc_o         = pc_q;

endmodule

/* hw/rv_pkg.sv */
// shared word types, opcode and alu enums, bus request struct, sequencer states
package rv_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;
   typedef logic [31:0] inst_t;
   typedef logic [4:0]  reg_addr_t;

   // major opcodes, encoded as inst[6:0]
   typedef enum logic [6:0] {
      ILLEGAL = 7'b0000000,
      LUI     = 7'b0110111,
      OP_IMM  = 7'b0010011,
      OP      = 7'b0110011,
      LOAD    = 7'b0000011,
      STORE   = 7'b0100011,
      BRANCH  = 7'b1100011,
      JAL     = 7'b1101111
   } op_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASS_B
   } alu_op_e;

   typedef enum logic [1:0] {
      FETCH,
      EXEC,
      MEM,
      WB
   } seq_state_e;

   // one request on the memory bus
   typedef struct packed {
      addr_t addr;
      word_t wdata;
      logic  we;
   } bus_req_t;

endpackage
